/* rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Datapath and register index widths
`define XLEN        32
`define REG_ADDR_W  5

// First fetch address out of reset
`define RESET_PC    32'h0000_0000

// Major opcodes of the kept RV32I subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// funct3 values, ALU group
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_SRL      3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 values, branch and memory group
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_WORD     3'b010

`endif

/* rv_core_pkg.sv */
`include "rv_core_config.svh"

package rv_core_pkg;

  ////////////////////
  // Instruction word
  ////////////////////

  // One 32-bit word, four views of the same bits
  // B and J immediates are rebuilt from the S and U views
  typedef union packed {
    // Register-register ops
    struct packed {
      logic [6:0]             funct7;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } r_fmt;
    // Immediate ops and loads
    struct packed {
      logic [11:0]            imm;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } i_fmt;
    // Stores, also carries the branch immediate bits
    struct packed {
      logic [6:0]             imm_hi;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [4:0]             imm_lo;
      logic [6:0]             opcode;
    } s_fmt;
    // LUI, also carries the JAL immediate bits
    struct packed {
      logic [19:0]            imm;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } u_fmt;
  } instr_u;

endpackage

/* rv_fetch_unit.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_fetch_unit (
  input  logic               clk_i,
  input  logic               rst_i,
  // Wishbone instruction master, read only
  output logic               iwb_cyc_o,
  output logic               iwb_stb_o,
  output logic [`XLEN-1:0]   iwb_adr_o,
  input  logic [`XLEN-1:0]   iwb_dat_i,
  input  logic               iwb_ack_i,
  // From execute and mem stage
  input  logic [`XLEN-1:0]   next_pc_i,
  input  logic               retire_i,
  // Current instruction to execute
  output rv_core_pkg::instr_u instr_o,
  output logic [`XLEN-1:0]   pc_o,
  output logic               exec_valid_o
);
  import rv_core_pkg::*;

  logic [`XLEN-1:0] pc_q;
  logic             fetch_q;
  logic             exec_valid_q;
  instr_u           instr_q;

  ////////////////////
  // Fetch FSM
  ////////////////////

  // fetch_q high: bus cycle open
  // exec_valid_q high: word held until retire
  // Both low only right after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q         <= `RESET_PC;
      fetch_q      <= 1'b0;
      exec_valid_q <= 1'b0;
    end else if (fetch_q) begin
      // Close the cycle on ack
      if (iwb_ack_i) begin
        fetch_q      <= 1'b0;
        exec_valid_q <= 1'b1;
      end
    end else if (exec_valid_q) begin
      // Retire edge, move on to the next PC
      if (retire_i) begin
        pc_q         <= next_pc_i;
        exec_valid_q <= 1'b0;
        fetch_q      <= 1'b1;
      end
    end else begin
      // Leave reset idle
      fetch_q <= 1'b1;
    end
  end

  // Instruction word captured on the ack
  always_ff @(posedge clk_i) begin
    if (fetch_q && iwb_ack_i) begin
      instr_q <= iwb_dat_i;
    end
  end

  // cyc and stb always together
  assign iwb_cyc_o    = fetch_q;
  assign iwb_stb_o    = fetch_q;
  // PC only moves on retire, so address stays put while stalled
  assign iwb_adr_o    = pc_q;

  assign instr_o      = instr_q;
  assign pc_o         = pc_q;
  assign exec_valid_o = exec_valid_q;

endmodule

/* rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_decoder (
  input  rv_core_pkg::instr_u     instr_i,
  output logic [`REG_ADDR_W-1:0]  rs1_o,
  output logic [`REG_ADDR_W-1:0]  rs2_o,
  output logic [`REG_ADDR_W-1:0]  rd_o,
  output logic [`XLEN-1:0]        imm_o,
  output logic                    use_imm_o,
  output logic                    is_sub_o,
  output logic                    is_lui_o,
  output logic                    is_load_o,
  output logic                    is_store_o,
  output logic                    is_branch_o,
  output logic                    is_jal_o,
  output logic                    rd_we_o,
  output logic [2:0]              alu_f3_o
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  // Opcode and funct3 sit at the same bits in every view
  assign opcode = instr_i.r_fmt.opcode;
  assign funct3 = instr_i.r_fmt.funct3;

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_i = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
  assign imm_s = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
  // B: imm[12|10:5] in imm_hi, imm[4:1|11] in imm_lo
  assign imm_b = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_lo[0],
                  instr_i.s_fmt.imm_hi[5:0], instr_i.s_fmt.imm_lo[4:1], 1'b0};
  assign imm_u = {instr_i.u_fmt.imm, 12'h000};
  // J: imm[20|10:1|11|19:12] packed into the U field
  assign imm_j = {{12{instr_i.u_fmt.imm[19]}}, instr_i.u_fmt.imm[7:0],
                  instr_i.u_fmt.imm[8], instr_i.u_fmt.imm[18:9], 1'b0};

  ////////////////////
  // Control decode
  ////////////////////

  always_comb begin
    // Defaults describe a no-op
    rs1_o       = instr_i.r_fmt.rs1;
    rs2_o       = instr_i.r_fmt.rs2;
    rd_o        = instr_i.r_fmt.rd;
    imm_o       = '0;
    use_imm_o   = 1'b0;
    is_sub_o    = 1'b0;
    is_lui_o    = 1'b0;
    is_load_o   = 1'b0;
    is_store_o  = 1'b0;
    is_branch_o = 1'b0;
    is_jal_o    = 1'b0;
    rd_we_o     = 1'b0;
    alu_f3_o    = `F3_ADD;
    case (opcode)
      `OPC_OP: begin
        rd_we_o  = 1'b1;
        alu_f3_o = funct3;
        // funct7 bit 5 selects SUB
        is_sub_o = instr_i.r_fmt.funct7[5] && (funct3 == `F3_ADD);
      end
      `OPC_OP_IMM: begin
        rd_o      = instr_i.i_fmt.rd;
        imm_o     = imm_i;
        use_imm_o = 1'b1;
        rd_we_o   = 1'b1;
        alu_f3_o  = funct3;
      end
      `OPC_LUI: begin
        rd_o      = instr_i.u_fmt.rd;
        imm_o     = imm_u;
        use_imm_o = 1'b1;
        is_lui_o  = 1'b1;
        rd_we_o   = 1'b1;
      end
      `OPC_LOAD: begin
        // Word loads only
        if (funct3 == `F3_WORD) begin
          rd_o      = instr_i.i_fmt.rd;
          imm_o     = imm_i;
          use_imm_o = 1'b1;
          is_load_o = 1'b1;
          rd_we_o   = 1'b1;
        end
      end
      `OPC_STORE: begin
        if (funct3 == `F3_WORD) begin
          imm_o      = imm_s;
          use_imm_o  = 1'b1;
          is_store_o = 1'b1;
        end
      end
      `OPC_BRANCH: begin
        // funct3 passed on for the compare
        imm_o       = imm_b;
        is_branch_o = 1'b1;
        alu_f3_o    = funct3;
      end
      `OPC_JAL: begin
        rd_o     = instr_i.u_fmt.rd;
        imm_o    = imm_j;
        is_jal_o = 1'b1;
        rd_we_o  = 1'b1;
      end
      default: begin
        // Anything else retires with no effect
        rd_we_o = 1'b0;
      end
    endcase
  end

endmodule

/* rv_reg_file.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_reg_file (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Read ports
  input  logic [`REG_ADDR_W-1:0] rs1_i,
  input  logic [`REG_ADDR_W-1:0] rs2_i,
  output logic [`XLEN-1:0]       rdata1_o,
  output logic [`XLEN-1:0]       rdata2_o,
  // Write port
  input  logic                   we_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i
);

  logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

  // Single write port, x0 never written
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  // x0 forced to zero
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_execute (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  rv_core_pkg::instr_u    instr_i,
  input  logic [`XLEN-1:0]       pc_i,
  // To mem stage
  output logic                   is_load_o,
  output logic                   is_store_o,
  output logic                   rd_we_o,
  output logic [`REG_ADDR_W-1:0] rd_o,
  output logic [`XLEN-1:0]       alu_result_o,
  output logic [`XLEN-1:0]       store_data_o,
  // To fetch
  output logic [`XLEN-1:0]       next_pc_o,
  // Writeback from mem stage
  input  logic                   wb_we_i,
  input  logic [`REG_ADDR_W-1:0] wb_addr_i,
  input  logic [`XLEN-1:0]       wb_data_i
);

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`XLEN-1:0]       imm;
  logic                   use_imm;
  logic                   is_sub;
  logic                   is_lui;
  logic                   is_branch;
  logic                   is_jal;
  logic [2:0]             alu_f3;
  logic [`XLEN-1:0]       rdata1;
  logic [`XLEN-1:0]       rdata2;
  logic [`XLEN-1:0]       op_a;
  logic [`XLEN-1:0]       op_b;
  logic [`XLEN-1:0]       alu_out;
  logic [`XLEN-1:0]       pc_plus4;
  logic [`XLEN-1:0]       target;
  logic                   take_branch;

  rv_decoder u_decoder (
    .instr_i     (instr_i),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd_o),
    .imm_o       (imm),
    .use_imm_o   (use_imm),
    .is_sub_o    (is_sub),
    .is_lui_o    (is_lui),
    .is_load_o   (is_load_o),
    .is_store_o  (is_store_o),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .rd_we_o     (rd_we_o),
    .alu_f3_o    (alu_f3)
  );

  rv_reg_file u_reg_file (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb_we_i),
    .waddr_i  (wb_addr_i),
    .wdata_i  (wb_data_i)
  );

  ////////////////////
  // ALU
  ////////////////////

  // LUI adds its immediate to zero
  assign op_a = is_lui ? '0 : rdata1;
  assign op_b = use_imm ? imm : rdata2;

  always_comb begin
    case (alu_f3)
      `F3_ADD: alu_out = is_sub ? (op_a - op_b) : (op_a + op_b);
      `F3_SLL: alu_out = op_a << op_b[4:0];
      `F3_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      `F3_XOR: alu_out = op_a ^ op_b;
      `F3_SRL: alu_out = op_a >> op_b[4:0];
      `F3_OR:  alu_out = op_a | op_b;
      `F3_AND: alu_out = op_a & op_b;
      default: alu_out = '0;
    endcase
  end

  ////////////////////
  // Next PC
  ////////////////////

  assign pc_plus4 = pc_i + `XLEN'd4;
  // Same target adder for branches and JAL
  assign target   = pc_i + imm;

  assign take_branch = is_branch &&
                       (((alu_f3 == `F3_BEQ) && (rdata1 == rdata2)) ||
                        ((alu_f3 == `F3_BNE) && (rdata1 != rdata2)));

  assign next_pc_o    = (is_jal || take_branch) ? target : pc_plus4;
  // JAL writes its link value
  assign alu_result_o = is_jal ? pc_plus4 : alu_out;
  assign store_data_o = rdata2;

endmodule

/* rv_mem_stage.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_mem_stage (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   exec_valid_i,
  // From execute
  input  logic                   is_load_i,
  input  logic                   is_store_i,
  input  logic                   rd_we_i,
  input  logic [`REG_ADDR_W-1:0] rd_i,
  input  logic [`XLEN-1:0]       alu_result_i,
  input  logic [`XLEN-1:0]       store_data_i,
  // Wishbone data master
  output logic                   dwb_cyc_o,
  output logic                   dwb_stb_o,
  output logic                   dwb_we_o,
  output logic [`XLEN-1:0]       dwb_adr_o,
  output logic [`XLEN-1:0]       dwb_dat_o,
  output logic [`XLEN/8-1:0]     dwb_sel_o,
  input  logic [`XLEN-1:0]       dwb_dat_i,
  input  logic                   dwb_ack_i,
  // Writeback to register file
  output logic                   wb_we_o,
  output logic [`REG_ADDR_W-1:0] wb_addr_o,
  output logic [`XLEN-1:0]       wb_data_o,
  // To fetch
  output logic                   retire_o
);

  logic mem_op;
  logic dbus_req;
  logic ack_seen_q;

  assign mem_op = is_load_i | is_store_i;

  ////////////////////
  // Data bus cycle
  ////////////////////

  // Set on the ack edge, cleared once the instruction is gone
  // Keeps one access per instruction
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_seen_q <= 1'b0;
    end else if (!exec_valid_i) begin
      ack_seen_q <= 1'b0;
    end else if (dbus_req && dwb_ack_i) begin
      ack_seen_q <= 1'b1;
    end
  end

  // Request opens in the first exec_valid cycle
  assign dbus_req  = exec_valid_i & mem_op & ~ack_seen_q;

  assign dwb_cyc_o = dbus_req;
  assign dwb_stb_o = dbus_req;
  assign dwb_we_o  = dbus_req & is_store_i;
  // Held stable by the stall, no register write until retire
  assign dwb_adr_o = alu_result_i;
  assign dwb_dat_o = store_data_i;
  // Word accesses only
  assign dwb_sel_o = {(`XLEN/8){1'b1}};

  ////////////////////
  // Retire and writeback
  ////////////////////

  // Non-memory ops retire at once, memory ops on the ack
  assign retire_o  = exec_valid_i & (mem_op ? (dbus_req & dwb_ack_i) : 1'b1);

  assign wb_we_o   = retire_o & rd_we_i;
  assign wb_addr_o = rd_i;
  // Load data is only valid in the ack cycle
  assign wb_data_o = is_load_i ? dwb_dat_i : alu_result_i;

endmodule

/* rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core (
  input  logic               clk_i,
  input  logic               rst_i,
  // Instruction bus
  output logic               iwb_cyc_o,
  output logic               iwb_stb_o,
  output logic [`XLEN-1:0]   iwb_adr_o,
  input  logic [`XLEN-1:0]   iwb_dat_i,
  input  logic               iwb_ack_i,
  // Data bus
  output logic               dwb_cyc_o,
  output logic               dwb_stb_o,
  output logic               dwb_we_o,
  output logic [`XLEN-1:0]   dwb_adr_o,
  output logic [`XLEN-1:0]   dwb_dat_o,
  output logic [`XLEN/8-1:0] dwb_sel_o,
  input  logic [`XLEN-1:0]   dwb_dat_i,
  input  logic               dwb_ack_i
);
  import rv_core_pkg::*;

  // Fetch to execute
  instr_u                 instr;
  logic [`XLEN-1:0]       pc;
  logic                   exec_valid;
  // Execute to mem stage
  logic                   is_load;
  logic                   is_store;
  logic                   rd_we;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       alu_result;
  logic [`XLEN-1:0]       store_data;
  logic [`XLEN-1:0]       next_pc;
  // Writeback and retire
  logic                   wb_we;
  logic [`REG_ADDR_W-1:0] wb_addr;
  logic [`XLEN-1:0]       wb_data;
  logic                   retire;

  ////////////////////
  // Input side
  ////////////////////

  rv_fetch_unit u_fetch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .iwb_cyc_o    (iwb_cyc_o),
    .iwb_stb_o    (iwb_stb_o),
    .iwb_adr_o    (iwb_adr_o),
    .iwb_dat_i    (iwb_dat_i),
    .iwb_ack_i    (iwb_ack_i),
    .next_pc_i    (next_pc),
    .retire_i     (retire),
    .instr_o      (instr),
    .pc_o         (pc),
    .exec_valid_o (exec_valid)
  );

  ////////////////////
  // Processing part
  ////////////////////

  rv_execute u_execute (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .instr_i      (instr),
    .pc_i         (pc),
    .is_load_o    (is_load),
    .is_store_o   (is_store),
    .rd_we_o      (rd_we),
    .rd_o         (rd),
    .alu_result_o (alu_result),
    .store_data_o (store_data),
    .next_pc_o    (next_pc),
    .wb_we_i      (wb_we),
    .wb_addr_i    (wb_addr),
    .wb_data_i    (wb_data)
  );

  ////////////////////
  // Output side
  ////////////////////

  rv_mem_stage u_mem (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .exec_valid_i (exec_valid),
    .is_load_i    (is_load),
    .is_store_i   (is_store),
    .rd_we_i      (rd_we),
    .rd_i         (rd),
    .alu_result_i (alu_result),
    .store_data_i (store_data),
    .dwb_cyc_o    (dwb_cyc_o),
    .dwb_stb_o    (dwb_stb_o),
    .dwb_we_o     (dwb_we_o),
    .dwb_adr_o    (dwb_adr_o),
    .dwb_dat_o    (dwb_dat_o),
    .dwb_sel_o    (dwb_sel_o),
    .dwb_dat_i    (dwb_dat_i),
    .dwb_ack_i    (dwb_ack_i),
    .wb_we_o      (wb_we),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data),
    .retire_o     (retire)
  );

endmodule

/* tb_rv_program.svh */
`ifndef TB_RV_PROGRAM_SVH
`define TB_RV_PROGRAM_SVH

// Linear congruential generator, one step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic logic [31:0] rnd_word();
  prog_seed = lcg_next(prog_seed);
  return prog_seed;
endfunction

//////////////////////
// Encoders
//////////////////////

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, `OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, `F3_WORD, imm[4:0], `OPC_STORE};
endfunction

// Branch offset in bytes, bit 0 dropped
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, `OPC_LUI};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
endfunction

//////////////////////
// Program builder
//////////////////////

task automatic emit(input logic [31:0] word);
  rom[prog_idx] = word;
  prog_idx++;
endtask

// LUI part corrected for ADDI sign extension
task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
  logic [11:0] lo;
  logic [31:0] hi;
  lo = v[11:0];
  hi = v - {{20{lo[11]}}, lo};
  emit(enc_u(hi[31:12], rd));
  emit(enc_i(lo, rd, `F3_ADD, rd, `OPC_OP_IMM));
endtask

// SW to the next free slot plus the expected write
task automatic store_check(input logic [4:0] rs2, input logic [31:0] val, input string name);
  emit(enc_s(st_off[11:0], rs2, 5'd0));
  exp_adr.push_back(st_off);
  exp_dat.push_back(val);
  exp_name.push_back(name);
  st_off = st_off + 32'd4;
endtask

task automatic build_program();
  logic [31:0] a;
  logic [31:0] b;
  logic [11:0] im;
  logic [31:0] ims;
  logic [31:0] jal_pc;
  a = rnd_word();
  b = rnd_word();
  if (a == b) b = ~a;
  load_const(5'd1, a);
  load_const(5'd2, b);
  load_const(5'd6, POISON);
  // Register-register ops, result always in x3
  emit(enc_r(7'h00, 5'd2, 5'd1, `F3_ADD, 5'd3));
  store_check(5'd3, a + b, "ADD");
  emit(enc_r(7'h20, 5'd2, 5'd1, `F3_ADD, 5'd3));
  store_check(5'd3, a - b, "SUB");
  emit(enc_r(7'h00, 5'd2, 5'd1, `F3_AND, 5'd3));
  store_check(5'd3, a & b, "AND");
  emit(enc_r(7'h00, 5'd2, 5'd1, `F3_OR, 5'd3));
  store_check(5'd3, a | b, "OR");
  emit(enc_r(7'h00, 5'd2, 5'd1, `F3_XOR, 5'd3));
  store_check(5'd3, a ^ b, "XOR");
  emit(enc_r(7'h00, 5'd2, 5'd1, `F3_SLT, 5'd3));
  store_check(5'd3, {31'b0, $signed(a) < $signed(b)}, "SLT");
  emit(enc_r(7'h00, 5'd2, 5'd1, `F3_SLL, 5'd3));
  store_check(5'd3, a << b[4:0], "SLL");
  emit(enc_r(7'h00, 5'd2, 5'd1, `F3_SRL, 5'd3));
  store_check(5'd3, a >> b[4:0], "SRL");
  // Immediate ops, one random immediate
  ims = rnd_word();
  im  = ims[11:0];
  ims = {{20{im[11]}}, im};
  emit(enc_i(im, 5'd1, `F3_ADD, 5'd3, `OPC_OP_IMM));
  store_check(5'd3, a + ims, "ADDI");
  emit(enc_i(im, 5'd1, `F3_AND, 5'd3, `OPC_OP_IMM));
  store_check(5'd3, a & ims, "ANDI");
  emit(enc_i(im, 5'd1, `F3_OR, 5'd3, `OPC_OP_IMM));
  store_check(5'd3, a | ims, "ORI");
  emit(enc_i(im, 5'd1, `F3_XOR, 5'd3, `OPC_OP_IMM));
  store_check(5'd3, a ^ ims, "XORI");
  emit(enc_i(im, 5'd1, `F3_SLT, 5'd3, `OPC_OP_IMM));
  store_check(5'd3, {31'b0, $signed(a) < $signed(ims)}, "SLTI");
  // Reload the ADD result from the first slot
  emit(enc_i(12'h100, 5'd0, `F3_WORD, 5'd4, `OPC_LOAD));
  emit(enc_i(im, 5'd4, `F3_ADD, 5'd5, `OPC_OP_IMM));
  store_check(5'd5, a + b + ims, "LW round trip");
  // x0 stays zero
  emit(enc_i(12'h07B, 5'd0, `F3_ADD, 5'd0, `OPC_OP_IMM));
  emit(enc_u(20'hABCDE, 5'd0));
  store_check(5'd0, 32'd0, "x0 write");
  // FENCE opcode with rd = x1, must be a no-op
  emit(enc_i(12'h3C5, 5'd1, 3'b000, 5'd1, 7'b0001111));
  store_check(5'd1, a, "unsupported opcode");
  // Taken branches jump over a poison store
  emit(enc_b(13'd8, 5'd2, 5'd1, `F3_BNE));
  emit(enc_s(POISON_OFF, 5'd6, 5'd0));
  emit(enc_b(13'd8, 5'd1, 5'd1, `F3_BEQ));
  emit(enc_s(POISON_OFF, 5'd6, 5'd0));
  // Not taken
  emit(enc_b(13'd8, 5'd2, 5'd1, `F3_BEQ));
  store_check(5'd1, a, "BEQ not taken");
  jal_pc = 32'(prog_idx * 4);
  emit(enc_j(21'd8, 5'd7));
  emit(enc_s(POISON_OFF, 5'd6, 5'd0));
  store_check(5'd7, jal_pc + 32'd4, "JAL link");
  // Park on a jump to itself
  emit(enc_j(21'd0, 5'd0));
endtask

`endif

/* tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module tb_rv_core;

  localparam logic [31:0] SEED       = 32'd99168;
  localparam logic [31:0] POISON     = 32'hDEAD_BEEF;
  localparam logic [11:0] POISON_OFF = 12'h3F0;

  logic        clk_i;
  logic        rst_i;
  logic        iwb_cyc_o;
  logic        iwb_stb_o;
  logic [31:0] iwb_adr_o;
  logic [31:0] iwb_dat_i;
  logic        iwb_ack_i;
  logic        dwb_cyc_o;
  logic        dwb_stb_o;
  logic        dwb_we_o;
  logic [31:0] dwb_adr_o;
  logic [31:0] dwb_dat_o;
  logic [3:0]  dwb_sel_o;
  logic [31:0] dwb_dat_i;
  logic        dwb_ack_i;

  // Memories and the expected store stream
  logic [31:0] rom [256];
  logic [31:0] ram [256];
  logic [31:0] exp_adr[$];
  logic [31:0] exp_dat[$];
  string       exp_name[$];
  logic [31:0] prog_seed;
  logic [31:0] st_off;
  int          prog_idx;
  int          errors;
  int          checked;

  `include "tb_rv_program.svh"

  rv_core dut (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .iwb_cyc_o (iwb_cyc_o),
    .iwb_stb_o (iwb_stb_o),
    .iwb_adr_o (iwb_adr_o),
    .iwb_dat_i (iwb_dat_i),
    .iwb_ack_i (iwb_ack_i),
    .dwb_cyc_o (dwb_cyc_o),
    .dwb_stb_o (dwb_stb_o),
    .dwb_we_o  (dwb_we_o),
    .dwb_adr_o (dwb_adr_o),
    .dwb_dat_o (dwb_dat_o),
    .dwb_sel_o (dwb_sel_o),
    .dwb_dat_i (dwb_dat_i),
    .dwb_ack_i (dwb_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////
  // Bus rules
  //////////////////////

  // Both masters idle in the second reset cycle
  assert property (@(posedge clk_i) rst_i && $past(rst_i) |-> !iwb_cyc_o && !dwb_cyc_o)
    else begin
      errors++;
      $display("cyc high during reset");
    end
  assert property (@(posedge clk_i) disable iff (rst_i)
                   (iwb_stb_o && !iwb_ack_i) |=> iwb_stb_o && $stable(iwb_adr_o))
    else begin
      errors++;
      $display("instruction request changed before ack");
    end
  assert property (@(posedge clk_i) disable iff (rst_i)
                   (dwb_stb_o && !dwb_ack_i) |=>
                   dwb_stb_o && $stable(dwb_adr_o) && $stable(dwb_we_o) && $stable(dwb_dat_o))
    else begin
      errors++;
      $display("data request changed before ack");
    end
  assert property (@(posedge clk_i) !(iwb_stb_o && !iwb_cyc_o))
    else begin
      errors++;
      $display("stb without cyc on the instruction bus");
    end
  assert property (@(posedge clk_i) !(dwb_stb_o && !dwb_cyc_o))
    else begin
      errors++;
      $display("stb without cyc on the data bus");
    end
  // Word accesses only, every byte lane enabled
  assert property (@(posedge clk_i) disable iff (rst_i) dwb_stb_o |-> dwb_sel_o == 4'hF)
    else begin
      errors++;
      $display("mismatch data byte select expected %h actual %h", 4'hF, dwb_sel_o);
    end

  //////////////////////
  // Instruction ROM slave
  //////////////////////

  initial begin
    int          iwait;
    logic [31:0] iseed;
    iwait = -1;
    iseed = SEED;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_i || iwb_ack_i) begin
        iwb_ack_i = 1'b0;
        iwait     = -1;
      end else if (iwb_cyc_o && iwb_stb_o) begin
        // 0 to 3 wait states per request
        if (iwait < 0) begin
          iseed = lcg_next(iseed);
          iwait = int'(iseed[17:16]);
        end
        if (iwait == 0) begin
          iwb_ack_i = 1'b1;
          iwb_dat_i = rom[iwb_adr_o[9:2]];
          iwait     = -1;
        end else begin
          iwait--;
        end
      end
    end
  end

  //////////////////////
  // Data RAM slave
  //////////////////////

  initial begin
    int          dwait;
    logic [31:0] dseed;
    dwait = -1;
    dseed = SEED ^ 32'h5A5A;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_i || dwb_ack_i) begin
        dwb_ack_i = 1'b0;
        dwait     = -1;
      end else if (dwb_cyc_o && dwb_stb_o) begin
        if (dwait < 0) begin
          dseed = lcg_next(dseed);
          dwait = int'(dseed[17:16]);
        end
        if (dwait == 0) begin
          dwb_ack_i = 1'b1;
          dwait     = -1;
          if (dwb_we_o) begin
            ram[dwb_adr_o[9:2]] = dwb_dat_o;
            assert (dwb_dat_o != POISON)
              else begin
                errors++;
                $display("poison value written at %h", dwb_adr_o);
              end
            // Compare against the next expected store
            if (exp_adr.size() == 0) begin
              errors++;
              $display("unexpected data write at %h", dwb_adr_o);
            end else begin
              checked++;
              assert (dwb_adr_o == exp_adr[0] && dwb_dat_o == exp_dat[0])
                else begin
                  errors++;
                  $display("mismatch %s expected %h at %h actual %h at %h", exp_name[0],
                           exp_dat[0], exp_adr[0], dwb_dat_o, dwb_adr_o);
                end
              void'(exp_adr.pop_front());
              void'(exp_dat.pop_front());
              void'(exp_name.pop_front());
            end
          end else begin
            dwb_dat_i = ram[dwb_adr_o[9:2]];
          end
        end else begin
          dwait--;
        end
      end
    end
  end

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin
    int cnt;
    rst_i     = 1'b1;
    iwb_dat_i = '0;
    iwb_ack_i = 1'b0;
    dwb_dat_i = '0;
    dwb_ack_i = 1'b0;
    errors    = 0;
    checked   = 0;
    prog_idx  = 0;
    prog_seed = SEED;
    st_off    = 32'h100;
    // Address-dependent fill, opcode 0 is a no-op
    for (int i = 0; i < 256; i++) begin
      rom[i] = {i[24:0], 7'b0000000};
      ram[i] = (i * 32'h9E37_79B9) ^ 32'h1234_5678;
    end
    build_program();
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // First request after reset
    cnt = 0;
    while (!iwb_cyc_o && cnt < 10) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!iwb_cyc_o) begin
      errors++;
      $display("no instruction request after reset");
    end else begin
      assert (iwb_adr_o == `RESET_PC)
        else begin
          errors++;
          $display("mismatch reset fetch expected %h actual %h", `RESET_PC, iwb_adr_o);
        end
    end
    // All expected stores seen
    cnt = 0;
    while (exp_adr.size() != 0 && cnt < 5000) begin
      @(negedge clk_i);
      cnt++;
    end
    if (exp_adr.size() != 0) begin
      errors++;
      $display("timeout with %0d stores still missing", exp_adr.size());
    end
    // Let the parked loop run to catch stray writes
    repeat (40) @(posedge clk_i);
    $display("errors %0d, stores checked %0d", errors, checked);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* rv_core.f */
+incdir+.
rv_core_pkg.sv
rv_fetch_unit.sv
rv_decoder.sv
rv_reg_file.sv
rv_execute.sv
rv_mem_stage.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o sim_rv_core && \
./obj_dir/sim_rv_core | tee /dev/stderr | grep -q "Verification passed" && \
echo "run.sh: simulation passed" || { echo "run.sh: simulation failed"; exit 1; }
